// ==== common/phase_pkg.sv ====
/* phase clock shared definitions */

package phase_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int PH_W    = 16;        // 2^PH_W is one full cycle
  localparam int ACC_W   = PH_W + 2;  // signed accumulator
  localparam int STEP_W  = 8;         // run length per command
  localparam int STAMP_W = 16;        // step index in reports, wraps

  ////////////////////
  // op codes
  ////////////////////

  localparam logic OP_FREQ  = 1'b0;  // load frequency word
  localparam logic OP_PHASE = 1'b1;  // load absolute phase

  ////////////////////
  // payloads
  ////////////////////

  // command from the producer, 25 bits
  typedef struct packed {
    logic              op;     // OP_FREQ or OP_PHASE
    logic [PH_W-1:0]   value;  // freq word or phase
    logic [STEP_W-1:0] steps;  // steps to run after the load
  } cmd_t;

  // edge report, 17 bits
  typedef struct packed {
    logic [STAMP_W-1:0] stamp;  // step index of the toggle
    logic               level;  // ckout after the toggle
  } edge_t;

endpackage

// ==== source/credit_fifo.sv ====
/* credit-returning FIFO */

`timescale 1ns/1ns

module credit_fifo #(
  parameter int  DEPTH     = 4,      // slots, also the sender's credits
  parameter type payload_t = logic   // stored record
) (
  input  logic                         ck,
  input  logic                         arst_n,
  input  logic                         push,       // write, sender holds a credit
  input  payload_t                     push_data,
  input  logic                         pop,        // read head
  output payload_t                     pop_data,   // head, show-ahead
  output logic                         empty,
  output logic [$clog2(DEPTH+1)-1:0]   count,      // occupancy
  output logic                         credit      // one pulse per pop
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH+1);

  payload_t           mem [DEPTH];  // storage
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic               pop_ok;       // pop of a real entry

  assign pop_ok   = pop & ~empty;
  assign empty    = (count == '0);
  assign pop_data = mem[rd_ptr];    // head visible without a read cycle

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge ck) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  ////////////////////
  // pointers, count, credit
  ////////////////////

  always_ff @(posedge ck or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;  // circular wrap
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop_ok})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;  // none or both
      endcase
      credit <= pop_ok;  // slot freed, hand it back next cycle
    end
  end

  // sender pushed without a credit
  a_no_push_full: assert property (@(posedge ck) disable iff (!arst_n)
    push |-> (count != CNT_W'(DEPTH)));

endmodule

// ==== phase2ck/phase_accum.sv ====
/* phase accumulator to clock */

`timescale 1ns/1ns

module phase_accum (
  input  logic                       ck,
  input  logic                       arst_n,
  input  logic                       step_en,     // advance one step
  input  logic                       freq_load,   // take value as freq word
  input  logic                       phase_load,  // take value as new phase
  input  logic [phase_pkg::PH_W-1:0] value,
  output logic                       toggle,      // ckout flips at this edge
  output logic                       ckout        // digital clock output
);

  import phase_pkg::*;

  localparam logic signed [ACC_W-1:0] HALF    = 2**(PH_W-1);  // half a cycle
  localparam logic signed [ACC_W-1:0] ACC_MIN = -(2**PH_W);   // floor of the accumulator

  logic signed [ACC_W-1:0] acc;         // accumulated phase
  logic        [PH_W-2:0]  freq_word;   // phase advance per step
  logic        [PH_W-1:0]  prev_phase;  // last loaded phase
  logic signed [PH_W-1:0]  jump;        // pending phase change
  logic signed [ACC_W-1:0] sum;         // acc + freq - jump
  logic signed [ACC_W-1:0] clamped;
  logic signed [ACC_W-1:0] acc_nxt;

  ////////////////////
  // step arithmetic
  ////////////////////

  always_comb begin
    sum     = acc
            + {{(ACC_W-PH_W+1){1'b0}}, freq_word}         // freq is unsigned
            - {{(ACC_W-PH_W){jump[PH_W-1]}}, jump};        // jump sign extended
    clamped = (sum < ACC_MIN) ? ACC_MIN : sum;             // floor for large negative jumps
    toggle  = step_en & (clamped > HALF);                  // strictly past half
    acc_nxt = toggle ? clamped - HALF : clamped;           // one flip per step at most
  end

  ////////////////////
  // state
  ////////////////////

  always_ff @(posedge ck or negedge arst_n) begin
    if (!arst_n) begin
      acc        <= '0;
      freq_word  <= '0;
      prev_phase <= '0;
      jump       <= '0;
      ckout      <= 1'b0;
    end else begin
      if (freq_load) begin
        freq_word <= value[PH_W-2:0];  // top bit dropped
      end
      if (phase_load) begin
        jump       <= signed'(value - prev_phase);  // wrapped difference
        prev_phase <= value;
      end else if (step_en) begin
        jump <= '0;  // applied once
      end
      if (step_en) begin
        acc <= acc_nxt;
      end
      if (toggle) begin
        ckout <= ~ckout;
      end
    end
  end

  // range holds over any run of steps and loads
  a_acc_range: assert property (@(posedge ck) disable iff (!arst_n)
    (acc >= ACC_MIN) && (acc <= HALF));

endmodule

// ==== source/edge_tx.sv ====
/* edge report sender */

`timescale 1ns/1ns

module edge_tx #(
  parameter int DEPTH = 4  // edge FIFO slots
) (
  input  logic                          ck,
  input  logic                          arst_n,
  input  logic                          step_en,      // a step happens this cycle
  input  logic                          toggle,       // ckout flips at this edge
  input  logic                          level,        // ckout before the flip
  output logic                          edge_room,    // a step may push safely
  output logic                          edge_valid,
  output logic [phase_pkg::STAMP_W-1:0] edge_stamp,
  output logic                          edge_level,
  input  logic                          edge_credit   // one per free sink slot
);

  import phase_pkg::*;

  localparam int CNT_W  = $clog2(DEPTH+1);
  localparam int CRED_W = 8;

  logic [STAMP_W-1:0] step_cnt;   // wrapping step index
  logic [CRED_W-1:0]  credits;    // held credits
  edge_t              rec;        // record being pushed
  edge_t              head;
  logic               fifo_empty;
  logic [CNT_W-1:0]   fifo_count;
  logic               send;       // pop and report this cycle

  assign rec.stamp = step_cnt;  // index of the current step
  assign rec.level = ~level;    // level after the flip
  assign edge_room = (fifo_count < CNT_W'(DEPTH));
  assign send      = ~fifo_empty & (credits != '0);

  credit_fifo #(
    .DEPTH     (DEPTH),
    .payload_t (edge_t)
  ) u_edge_fifo (
    .ck        (ck),
    .arst_n    (arst_n),
    .push      (toggle),
    .push_data (rec),
    .pop       (send),
    .pop_data  (head),
    .empty     (fifo_empty),
    .count     (fifo_count),
    .credit    ()
  );

  always_ff @(posedge ck or negedge arst_n) begin
    if (!arst_n) begin
      step_cnt   <= '0;
      credits    <= '0;
      edge_valid <= 1'b0;
    end else begin
      if (step_en) begin
        step_cnt <= step_cnt + 1'b1;
      end
      credits    <= credits + CRED_W'(edge_credit) - CRED_W'(send);  // earn and spend
      edge_valid <= send;
    end
  end

  always_ff @(posedge ck) begin
    if (send) begin
      edge_stamp <= head.stamp;
      edge_level <= head.level;
    end
  end

  // sink returned more credits than the counter holds
  a_credit_room: assert property (@(posedge ck) disable iff (!arst_n)
    (edge_credit && !send) |-> (credits != '1));

endmodule

// ==== source/ph_ctrl.sv ====
/* command sequencer */

`timescale 1ns/1ns

module ph_ctrl (
  input  logic                         ck,
  input  logic                         arst_n,
  input  logic                         cmd_empty,   // command FIFO has nothing
  output logic                         cmd_pop,
  input  logic                         cmd_op,      // head of the command FIFO
  input  logic [phase_pkg::PH_W-1:0]   cmd_value,
  input  logic [phase_pkg::STEP_W-1:0] cmd_steps,
  input  logic                         edge_room,   // edge FIFO can take a push
  output logic                         step_en,
  output logic                         freq_load,
  output logic                         phase_load,
  output logic [phase_pkg::PH_W-1:0]   value        // load operand
);

  import phase_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,   // wait for a command
    S_APPLY,  // issue the load
    S_RUN     // step the accumulator
  } state_t;

  state_t            state;
  state_t            state_nxt;
  logic              op_q;       // latched command
  logic [PH_W-1:0]   value_q;
  logic [STEP_W-1:0] steps_q;
  logic [STEP_W-1:0] remaining;  // steps left in the run

  ////////////////////
  // outputs
  ////////////////////

  assign cmd_pop    = (state == S_IDLE) & ~cmd_empty;
  assign freq_load  = (state == S_APPLY) & (op_q == OP_FREQ);
  assign phase_load = (state == S_APPLY) & (op_q == OP_PHASE);
  assign value      = value_q;
  assign step_en    = (state == S_RUN) & edge_room;  // freeze while reports back up

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE: begin
        if (!cmd_empty) begin
          state_nxt = S_APPLY;
        end
      end
      S_APPLY: begin
        state_nxt = (steps_q == '0) ? S_IDLE : S_RUN;  // zero steps only loads
      end
      S_RUN: begin
        if (step_en && (remaining == STEP_W'(1))) begin
          state_nxt = S_IDLE;  // last step taken
        end
      end
      default: state_nxt = S_IDLE;
    endcase
  end

  ////////////////////
  // control state
  ////////////////////

  always_ff @(posedge ck or negedge arst_n) begin
    if (!arst_n) begin
      state     <= S_IDLE;
      remaining <= '0;
    end else begin
      state <= state_nxt;
      if (state == S_APPLY) begin
        remaining <= steps_q;  // arm the run
      end else if (step_en) begin
        remaining <= remaining - 1'b1;
      end
    end
  end

  // command payload, captured on pop
  always_ff @(posedge ck) begin
    if (cmd_pop) begin
      op_q    <= cmd_op;
      value_q <= cmd_value;
      steps_q <= cmd_steps;
    end
  end

endmodule

// ==== source/phase_clk_top.sv ====
/* phase to clock top */

`timescale 1ns/1ns

module phase_clk_top #(
  parameter int CMD_DEPTH  = 4,  // command credits
  parameter int EDGE_DEPTH = 4   // edge FIFO slots
) (
  input  logic                          ck,
  input  logic                          arst_n,
  // command channel
  input  logic                          cmd_valid,
  input  logic                          cmd_op,
  input  logic [phase_pkg::PH_W-1:0]    cmd_value,
  input  logic [phase_pkg::STEP_W-1:0]  cmd_steps,
  output logic                          cmd_credit,
  // edge channel
  output logic                          edge_valid,
  output logic [phase_pkg::STAMP_W-1:0] edge_stamp,
  output logic                          edge_level,
  input  logic                          edge_credit,
  // clock out
  output logic                          ckout
);

  import phase_pkg::*;

  cmd_t            cmd_in;      // channel to FIFO
  cmd_t            cmd_head;    // FIFO to sequencer
  logic            cmd_pop;
  logic            cmd_empty;
  logic            step_en;
  logic            freq_load;
  logic            phase_load;
  logic [PH_W-1:0] ld_value;
  logic            toggle;
  logic            edge_room;

  assign cmd_in.op    = cmd_op;
  assign cmd_in.value = cmd_value;
  assign cmd_in.steps = cmd_steps;

  ////////////////////
  // command path
  ////////////////////

  credit_fifo #(
    .DEPTH     (CMD_DEPTH),
    .payload_t (cmd_t)
  ) u_cmd_fifo (
    .ck        (ck),
    .arst_n    (arst_n),
    .push      (cmd_valid),
    .push_data (cmd_in),
    .pop       (cmd_pop),
    .pop_data  (cmd_head),
    .empty     (cmd_empty),
    .count     (),            // credits track occupancy outside
    .credit    (cmd_credit)
  );

  ph_ctrl u_ctrl (
    .ck         (ck),
    .arst_n     (arst_n),
    .cmd_empty  (cmd_empty),
    .cmd_pop    (cmd_pop),
    .cmd_op     (cmd_head.op),
    .cmd_value  (cmd_head.value),
    .cmd_steps  (cmd_head.steps),
    .edge_room  (edge_room),
    .step_en    (step_en),
    .freq_load  (freq_load),
    .phase_load (phase_load),
    .value      (ld_value)
  );

  ////////////////////
  // clock and reports
  ////////////////////

  phase_accum u_accum (
    .ck         (ck),
    .arst_n     (arst_n),
    .step_en    (step_en),
    .freq_load  (freq_load),
    .phase_load (phase_load),
    .value      (ld_value),
    .toggle     (toggle),
    .ckout      (ckout)
  );

  edge_tx #(
    .DEPTH (EDGE_DEPTH)
  ) u_edge_tx (
    .ck          (ck),
    .arst_n      (arst_n),
    .step_en     (step_en),
    .toggle      (toggle),
    .level       (ckout),  // pre-flip level
    .edge_room   (edge_room),
    .edge_valid  (edge_valid),
    .edge_stamp  (edge_stamp),
    .edge_level  (edge_level),
    .edge_credit (edge_credit)
  );

endmodule

// ==== sim/phase_model.svh ====
/* phase to clock reference model */

// walks the command list with the accumulator rules, one entry per toggle
function automatic void phase_model(input cmd_t cmds[$], output edge_t exp_q[$]);
  int                 acc;    // accumulated phase
  int                 freq;   // advance per step
  int                 jump;   // pending phase change
  logic [PH_W-1:0]    prev;   // last loaded phase
  logic [PH_W-1:0]    diff;
  logic [STAMP_W-1:0] stamp;  // step index, wraps
  logic               level;
  edge_t              e;
  acc   = 0;
  freq  = 0;
  jump  = 0;
  prev  = '0;
  stamp = '0;
  level = 1'b0;
  exp_q = {};
  foreach (cmds[i]) begin
    if (cmds[i].op == OP_FREQ) begin
      freq = int'(cmds[i].value[PH_W-2:0]);  // top bit ignored
    end else begin
      diff = cmds[i].value - prev;           // wrapped difference
      jump = int'($signed(diff));
      prev = cmds[i].value;
    end
    for (int s = 0; s < int'(cmds[i].steps); s++) begin
      acc  = acc + freq - jump;
      jump = 0;                              // applied once
      if (acc < -(2**PH_W)) begin
        acc = -(2**PH_W);                    // floor
      end
      if (acc > 2**(PH_W-1)) begin
        acc     = acc - 2**(PH_W-1);
        level   = ~level;
        e.stamp = stamp;
        e.level = level;
        exp_q.push_back(e);
      end
      stamp = stamp + 1'b1;
    end
  end
endfunction

// ==== sim/tb_phase_clk.sv ====
/* phase clock testbench */

`timescale 1ns/1ns

module tb_phase_clk;

  import phase_pkg::*;

  `include "phase_model.svh"

  localparam int CMD_DEPTH    = 4;
  localparam int EDGE_DEPTH   = 4;
  localparam int SINK_SLOTS   = 4;    // sink buffer slots handed out as credits
  localparam int DRAIN_CYCLES = 300;  // longer than any single run

  logic               ck = 1'b0;
  logic               arst_n;
  logic               cmd_valid;
  logic               cmd_op;
  logic [PH_W-1:0]    cmd_value;
  logic [STEP_W-1:0]  cmd_steps;
  logic               cmd_credit;
  logic               edge_valid;
  logic [STAMP_W-1:0] edge_stamp;
  logic               edge_level;
  logic               edge_credit;
  logic               ckout;

  cmd_t   cmds[$];              // command list
  edge_t  exp_q[$];             // expected reports in order
  integer seed;
  int     n_exp      = 0;
  int     sum_steps  = 0;
  int     limit      = 0;       // timeout in cycles
  int     cycle      = 0;
  int     sent       = 0;
  int     cmd_cred   = CMD_DEPTH;
  int     cmd_pulses = 0;
  int     owed       = SINK_SLOTS;  // credits the sink still has to return
  int     given      = 0;
  int     rx_count   = 0;
  int     val_errs   = 0;
  int     prot_errs  = 0;
  logic   started    = 1'b0;
  logic   drain      = 1'b0;    // stop withholding credits

  always #5 ck = ~ck;

  phase_clk_top #(
    .CMD_DEPTH  (CMD_DEPTH),
    .EDGE_DEPTH (EDGE_DEPTH)
  ) u_phase_clk_top (
    .ck          (ck),
    .arst_n      (arst_n),
    .cmd_valid   (cmd_valid),
    .cmd_op      (cmd_op),
    .cmd_value   (cmd_value),
    .cmd_steps   (cmd_steps),
    .cmd_credit  (cmd_credit),
    .edge_valid  (edge_valid),
    .edge_stamp  (edge_stamp),
    .edge_level  (edge_level),
    .edge_credit (edge_credit),
    .ckout       (ckout)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual) else begin
      val_errs++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic add_cmd(input logic op, input logic [PH_W-1:0] value,
                         input logic [STEP_W-1:0] steps);
    cmd_t c;
    c.op    = op;
    c.value = value;
    c.steps = steps;
    cmds.push_back(c);
    sum_steps += int'(steps);
  endtask

  ////////////////////
  // timeout
  ////////////////////

  always @(posedge ck) begin
    cycle++;
    if (limit != 0 && cycle >= limit) begin
      $display("timeout after %0d cycles, reports or command credits never arrived", cycle);
      $display("errors: %0d value, %0d protocol", val_errs, prot_errs);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////
  // command sender
  ////////////////////

  always @(posedge ck) begin
    #1;
    if (cmd_credit) begin
      cmd_cred++;    // slot freed in the DUT
      cmd_pulses++;
    end
    if (started && cmd_cred > 0 && sent < cmds.size()) begin
      cmd_valid = 1'b1;
      cmd_op    = cmds[sent].op;
      cmd_value = cmds[sent].value;
      cmd_steps = cmds[sent].steps;
      cmd_cred--;
      sent++;
    end else begin
      cmd_valid = 1'b0;
    end
  end

  ////////////////////
  // edge sink and compare
  ////////////////////

  always @(posedge ck) begin
    edge_t e;
    logic  hold;
    #1;
    if (edge_valid) begin
      rx_count++;
      owed++;  // sink consumes at once
      assert (rx_count <= given) else begin
        prot_errs++;
        $display("report %0d arrived without a credit given for it", rx_count);
      end
      assert (exp_q.size() > 0) else begin
        prot_errs++;
        $display("extra report beyond the expected sequence, stamp %h", edge_stamp);
      end
      if (exp_q.size() > 0) begin
        e = exp_q.pop_front();
        check_value("edge_stamp", 32'(e.stamp), 32'(edge_stamp));
        check_value("edge_level", 32'(e.level), 32'(edge_level));
      end
    end
    // every other 128 cycles most credits are held back
    hold = !drain && ((cycle / 128) % 2 == 1) && (($random(seed) & 3) != 0);
    if (started && owed > 0 && !hold) begin
      edge_credit = 1'b1;
      owed--;
      given++;
    end else begin
      edge_credit = 1'b0;
    end
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : main
    logic [PH_W-1:0]   ph;
    logic [PH_W-1:0]   freq_r;
    logic [STEP_W-1:0] steps_r;
    int                delta;
    logic              last_level;
    seed        = 32'h56e0;
    arst_n      = 1'b0;
    cmd_valid   = 1'b0;
    cmd_op      = 1'b0;
    cmd_value   = '0;
    cmd_steps   = '0;
    edge_credit = 1'b0;
    add_cmd(OP_FREQ,  16'd6000,  8'd40);  // steady run
    add_cmd(OP_PHASE, 16'd8000,  8'd20);  // delay
    add_cmd(OP_PHASE, 16'd0,     8'd20);  // advance back
    add_cmd(OP_FREQ,  16'd3000,  8'd60);  // slower
    add_cmd(OP_PHASE, 16'd30000, 8'd1);   // four big delays down to the floor
    add_cmd(OP_PHASE, 16'd60000, 8'd1);
    add_cmd(OP_PHASE, 16'd24464, 8'd1);   // wrapped value still moves +30000
    add_cmd(OP_PHASE, 16'd54464, 8'd1);
    add_cmd(OP_FREQ,  16'd8000,  8'd40);
    add_cmd(OP_PHASE, 16'd40000, 8'd30);  // negative jump
    add_cmd(OP_PHASE, 16'd50000, 8'd0);   // load only
    add_cmd(OP_FREQ,  16'd5000,  8'd60);
    ph = 16'd50000;
    for (int i = 0; i < 8; i++) begin
      freq_r  = 16'(1000 + ($random(seed) & 32'h1fff));
      steps_r = 8'(20 + ($random(seed) & 32'h3f));
      add_cmd(OP_FREQ, freq_r, steps_r);
      delta   = $random(seed) % 8000;  // small move either way
      ph      = ph + 16'(delta);
      steps_r = 8'(5 + ($random(seed) & 32'hf));
      add_cmd(OP_PHASE, ph, steps_r);
    end
    phase_model(cmds, exp_q);
    n_exp      = exp_q.size();
    last_level = (n_exp > 0) ? exp_q[n_exp-1].level : 1'b0;
    limit      = 4 * (sum_steps + cmds.size()) + 1000;
    repeat (4) @(posedge ck);
    #1;
    arst_n = 1'b1;
    check_value("ckout", 32'd0, 32'(ckout));
    check_value("edge_valid", 32'd0, 32'(edge_valid));
    check_value("cmd_credit", 32'd0, 32'(cmd_credit));
    @(posedge ck);
    started = 1'b1;
    wait (cmd_pulses == cmds.size() && rx_count >= n_exp);
    drain = 1'b1;
    repeat (DRAIN_CYCLES) @(posedge ck);  // catch late or extra reports
    #2;
    check_value("cmd_credit pulses", 32'(cmds.size()), 32'(cmd_pulses));
    check_value("reports received", 32'(n_exp), 32'(rx_count));
    check_value("ckout", 32'(last_level), 32'(ckout));
    $display("errors: %0d value, %0d protocol", val_errs, prot_errs);
    if (val_errs == 0 && prot_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+sim
common/phase_pkg.sv
source/credit_fifo.sv
phase2ck/phase_accum.sv
source/edge_tx.sv
source/ph_ctrl.sv
source/phase_clk_top.sv
sim/tb_phase_clk.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the phase clock testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_phase_clk -f filelist.f
out="$(./obj_dir/Vtb_phase_clk)"
echo "$out"
if grep -q "^Testbench passed$" <<< "$out"; then
  exit 0
fi
exit 1
